/* csr_pkg.sv */
package csr_pkg;

	typedef logic [31:0] xlen_t;
	typedef logic [11:0] csr_addr_t;
	typedef logic [63:0] time_t;

	// machine level
	localparam csr_addr_t CSR_MVENDORID = 12'hf11;
	localparam csr_addr_t CSR_MARCHID   = 12'hf12;
	localparam csr_addr_t CSR_MIMPID    = 12'hf13;
	localparam csr_addr_t CSR_MHARTID   = 12'hf14;
	localparam csr_addr_t CSR_MSTATUS   = 12'h300;
	localparam csr_addr_t CSR_MISA      = 12'h301;
	localparam csr_addr_t CSR_MEDELEG   = 12'h302;
	localparam csr_addr_t CSR_MIDELEG   = 12'h303;
	localparam csr_addr_t CSR_MIE       = 12'h304;
	localparam csr_addr_t CSR_MTVEC     = 12'h305;
	localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
	localparam csr_addr_t CSR_MEPC      = 12'h341;
	localparam csr_addr_t CSR_MCAUSE    = 12'h342;
	localparam csr_addr_t CSR_MTVAL     = 12'h343;
	localparam csr_addr_t CSR_MIP       = 12'h344;
	localparam csr_addr_t CSR_MTIMECMP  = 12'hbbf; // custom slot, low word only

	// supervisor level
	localparam csr_addr_t CSR_SSTATUS   = 12'h100;
	localparam csr_addr_t CSR_SIE       = 12'h104;
	localparam csr_addr_t CSR_STVEC     = 12'h105;
	localparam csr_addr_t CSR_SSCRATCH  = 12'h140;
	localparam csr_addr_t CSR_SEPC      = 12'h141;
	localparam csr_addr_t CSR_SCAUSE    = 12'h142;
	localparam csr_addr_t CSR_STVAL     = 12'h143;
	localparam csr_addr_t CSR_SIP       = 12'h144;

	// cycle and time share one counter
	localparam csr_addr_t CSR_CYCLE     = 12'hc00;
	localparam csr_addr_t CSR_TIME      = 12'hc01;
	localparam csr_addr_t CSR_CYCLEH    = 12'hc80;
	localparam csr_addr_t CSR_TIMEH     = 12'hc81;

	// RV32 with I, M, N, S, U
	localparam xlen_t MISA_VALUE = {2'b01, 4'b0000, 26'b00000101000011000100000000};

	localparam xlen_t       EPC_WMASK    = 32'hffff_fffc;
	localparam xlen_t       TVEC_WMASK   = 32'hffff_fffc; // direct mode only
	localparam xlen_t       CAUSE_WMASK  = 32'h8000_003f; // interrupt flag and code
	localparam logic [15:0] MIDELEG_MASK = 16'h0fff;

endpackage

/* trap_pkg.sv */
package trap_pkg;

	typedef enum logic [1:0] {
		PRIV_U = 2'b00,
		PRIV_S = 2'b01,
		PRIV_R = 2'b10, // reserved encoding
		PRIV_M = 2'b11
	} priv_mode_t;

	localparam int CAUSE_INT_BIT = 31;
	localparam int CAUSE_CODE_W  = 4; // enough to index the 16-bit delegation regs

	typedef logic [CAUSE_CODE_W-1:0] cause_code_t;

	// synchronous exceptions
	localparam cause_code_t EXC_I_ADDR_MISALIGNED = 4'd0;
	localparam cause_code_t EXC_I_ACCESS_FAULT    = 4'd1;
	localparam cause_code_t EXC_I_ILLEGAL         = 4'd2;
	localparam cause_code_t EXC_BREAKPOINT        = 4'd3;
	localparam cause_code_t EXC_L_ADDR_MISALIGNED = 4'd4;
	localparam cause_code_t EXC_L_ACCESS_FAULT    = 4'd5;
	localparam cause_code_t EXC_S_ADDR_MISALIGNED = 4'd6;
	localparam cause_code_t EXC_S_ACCESS_FAULT    = 4'd7;
	localparam cause_code_t EXC_U_CALL            = 4'd8;
	localparam cause_code_t EXC_S_CALL            = 4'd9;
	localparam cause_code_t EXC_M_CALL            = 4'd11;

	// interrupts, flagged by CAUSE_INT_BIT
	localparam cause_code_t INT_S_SW    = 4'd1;
	localparam cause_code_t INT_M_SW    = 4'd3;
	localparam cause_code_t INT_S_TIMER = 4'd5;
	localparam cause_code_t INT_M_TIMER = 4'd7;
	localparam cause_code_t INT_S_EXT   = 4'd9;
	localparam cause_code_t INT_M_EXT   = 4'd11;

endpackage

/* trap_router.sv */
`timescale 1ns/1ps

module trap_router
	import csr_pkg::*, trap_pkg::*;
(
	input  logic        exception_pending,
	input  xlen_t       cause,
	input  logic        m_ret,
	input  logic        s_ret,
	input  priv_mode_t  current_mode,
	input  priv_mode_t  mpp,
	input  logic        spp,
	input  logic [15:0] medeleg,
	input  logic [15:0] mideleg,
	output priv_mode_t  next_mode
);

	cause_code_t code;
	logic        delegated;

	assign code = cause[CAUSE_CODE_W-1:0];

	// interrupts look at mideleg, exceptions at medeleg
	assign delegated = cause[CAUSE_INT_BIT] ? mideleg[code] : medeleg[code];

	always_comb
	begin
		next_mode = current_mode; // hold by default
		if (exception_pending)
			next_mode = delegated ? PRIV_S : PRIV_M;
		else if (m_ret)
			next_mode = mpp;
		else if (s_ret)
			next_mode = spp ? PRIV_S : PRIV_U;
	end

	// both returns come from one retiring instruction, so never together
	always_comb
	begin
		assert (!(m_ret && s_ret))
			else $error("m_ret and s_ret asserted in the same cycle");
	end

endmodule

/* csr_state.sv */
`timescale 1ns/1ps

module csr_state
	import csr_pkg::*, trap_pkg::*;
(
	input  logic        clk,
	input  logic        nrst,
	input  logic        csr_we,
	input  csr_addr_t   csr_address_wb,
	input  xlen_t       csr_wb,
	input  logic        exception_pending,
	input  xlen_t       cause,
	input  xlen_t       pc_exc,
	input  logic        m_ret,
	input  logic        s_ret,
	input  priv_mode_t  next_mode,
	output priv_mode_t  current_mode,
	output priv_mode_t  mpp,
	output logic        spp,
	output xlen_t       mstatus_word,
	output xlen_t       sstatus_word,
	output xlen_t       mie_word,
	output xlen_t       sie_word,
	output xlen_t       mtvec,
	output xlen_t       stvec,
	output xlen_t       mepc,
	output xlen_t       sepc,
	output xlen_t       mcause,
	output xlen_t       scause,
	output xlen_t       mtval,
	output xlen_t       stval,
	output xlen_t       mscratch,
	output xlen_t       sscratch,
	output logic [15:0] medeleg,
	output logic [15:0] mideleg,
	output logic        m_eie,
	output logic        m_tie,
	output logic        s_eie,
	output logic        s_tie,
	output logic        tsr
);

	logic sie, mie, spie, mpie, sum;
	logic seie, meie, stie, mtie;
	xlen_t tval_next;

	// faulting pc for a misaligned fetch, zero for anything else
	function automatic xlen_t trap_value(input xlen_t c, input xlen_t pc);
		xlen_t v;
		v = '0;
		if (!c[CAUSE_INT_BIT] && c[CAUSE_INT_BIT-1:CAUSE_CODE_W] == '0)
		begin
			case (cause_code_t'(c[CAUSE_CODE_W-1:0]))
				EXC_I_ADDR_MISALIGNED: v = {pc[31:1], 1'b0};
				EXC_I_ILLEGAL:         v = '0; // instruction word not available here
				default:               v = '0;
			endcase
		end
		return v;
	endfunction

	assign tval_next = trap_value(cause, pc_exc);

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			current_mode <= PRIV_M;
			mpp <= PRIV_M;
			{spp, sie, mie, spie, mpie, sum, tsr} <= '0;
			{seie, meie, stie, mtie} <= '0;
			{mtvec, stvec, mepc, sepc} <= '0;
			{mcause, scause, mtval, stval, mscratch, sscratch} <= '0;
			medeleg <= '0;
			mideleg <= '0;
		end
		else
		begin
			current_mode <= next_mode;
			if (exception_pending && next_mode == PRIV_M)
			begin
				mepc <= pc_exc & EPC_WMASK;
				mcause <= cause;
				mtval <= tval_next;
				mie <= 1'b0;
				mpie <= mie;
				mpp <= current_mode;
			end
			else if (exception_pending)
			begin
				// delegated to S
				sepc <= pc_exc & EPC_WMASK;
				scause <= cause;
				stval <= tval_next;
				sie <= 1'b0;
				spie <= sie;
				spp <= current_mode[0];
			end
			else if (m_ret)
			begin
				mie <= mpie;
				mpie <= 1'b1;
				mpp <= PRIV_U;
			end
			else if (s_ret)
			begin
				sie <= spie;
				spie <= 1'b1;
				spp <= 1'b0;
			end
			else if (csr_we)
			begin
				case (csr_address_wb)
					CSR_MSTATUS:
					begin
						sie <= csr_wb[1];
						mie <= csr_wb[3];
						spie <= csr_wb[5];
						mpie <= csr_wb[7];
						spp <= csr_wb[8];
						if (csr_wb[12:11] != PRIV_R) // reserved mode keeps old mpp
							mpp <= priv_mode_t'(csr_wb[12:11]);
						sum <= csr_wb[18];
						tsr <= csr_wb[22];
					end
					CSR_SSTATUS:
					begin
						sie <= csr_wb[1];
						spie <= csr_wb[5];
						spp <= csr_wb[8];
						sum <= csr_wb[18];
					end
					CSR_MIE:
					begin
						stie <= csr_wb[5];
						mtie <= csr_wb[7];
						seie <= csr_wb[9];
						meie <= csr_wb[11];
					end
					CSR_SIE:
					begin
						stie <= csr_wb[5];
						seie <= csr_wb[9];
					end
					CSR_MTVEC:    mtvec <= csr_wb & TVEC_WMASK;
					CSR_STVEC:    stvec <= csr_wb & TVEC_WMASK;
					CSR_MEPC:     mepc <= csr_wb & EPC_WMASK;
					CSR_SEPC:     sepc <= csr_wb & EPC_WMASK;
					CSR_MCAUSE:   mcause <= csr_wb & CAUSE_WMASK;
					CSR_SCAUSE:   scause <= csr_wb & CAUSE_WMASK;
					CSR_MTVAL:    mtval <= csr_wb;
					CSR_STVAL:    stval <= csr_wb;
					CSR_MSCRATCH: mscratch <= csr_wb;
					CSR_SSCRATCH: sscratch <= csr_wb;
					CSR_MEDELEG:  medeleg <= csr_wb[15:0];
					CSR_MIDELEG:  mideleg <= csr_wb[15:0] & MIDELEG_MASK;
					default: ; // time compare lives in the timer
				endcase
			end
		end
	end

	always_comb
	begin
		mstatus_word = '0;
		mstatus_word[1] = sie;
		mstatus_word[3] = mie;
		mstatus_word[5] = spie;
		mstatus_word[7] = mpie;
		mstatus_word[8] = spp;
		mstatus_word[12:11] = mpp;
		mstatus_word[18] = sum;
		mstatus_word[22] = tsr;
		sstatus_word = mstatus_word & 32'h0004_0122; // S view: sie, spie, spp, sum
		mie_word = {20'b0, meie, 1'b0, seie, 1'b0, mtie, 1'b0, stie, 5'b0};
		sie_word = {22'b0, seie, 3'b0, stie, 5'b0};
	end

	// enables gated by the global bit of their mode
	assign m_eie = meie && mie;
	assign m_tie = mtie && mie;
	assign s_eie = seie && sie;
	assign s_tie = stie && sie;

	// router and status writes together must never reach the reserved mode
	assert property (@(posedge clk) disable iff (!nrst) current_mode != PRIV_R)
		else $error("current_mode entered reserved encoding");

endmodule

/* machine_timer.sv */
`timescale 1ns/1ps

module machine_timer
	import csr_pkg::*;
(
	input  logic      clk,
	input  logic      nrst,
	input  logic      csr_we,
	input  csr_addr_t csr_address_wb,
	input  xlen_t     csr_wb,
	input  logic      exception_pending,
	output time_t     time_value,
	output xlen_t     mtimecmp,
	output logic      m_timer
);

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			time_value <= '0;
			mtimecmp <= '0;
			m_timer <= 1'b0;
		end
		else
		begin
			time_value <= time_value + 64'd1; // free running and also read as cycle
			if (csr_we && !exception_pending && csr_address_wb == CSR_MTIMECMP)
				mtimecmp <= csr_wb;
			m_timer <= (time_value >= {32'b0, mtimecmp});
		end
	end

endmodule

/* csr_read_port.sv */
`timescale 1ns/1ps

module csr_read_port
	import csr_pkg::*, trap_pkg::*;
(
	input  csr_addr_t   csr_address_r,
	input  priv_mode_t  next_mode,
	input  logic        m_ret,
	input  logic        s_ret,
	input  xlen_t       mstatus_word,
	input  xlen_t       sstatus_word,
	input  xlen_t       mie_word,
	input  xlen_t       sie_word,
	input  xlen_t       mtvec,
	input  xlen_t       stvec,
	input  xlen_t       mepc,
	input  xlen_t       sepc,
	input  xlen_t       mcause,
	input  xlen_t       scause,
	input  xlen_t       mtval,
	input  xlen_t       stval,
	input  xlen_t       mscratch,
	input  xlen_t       sscratch,
	input  logic [15:0] medeleg,
	input  logic [15:0] mideleg,
	input  time_t       time_value,
	input  xlen_t       mtimecmp,
	input  logic        m_timer,
	input  logic        m_interrupt,
	input  logic        s_interrupt,
	output xlen_t       csr_data,
	output xlen_t       epc
);

	xlen_t mip_word;
	xlen_t sip_word;

	// STIP stays zero, there is no supervisor timer
	assign mip_word = {20'b0, m_interrupt, 1'b0, s_interrupt, 1'b0, m_timer, 1'b0, 1'b0, 5'b0};
	assign sip_word = {22'b0, s_interrupt, 3'b0, 1'b0, 5'b0};

	always_comb
	begin
		case (csr_address_r)
			CSR_MISA:                         csr_data = MISA_VALUE;
			CSR_MVENDORID, CSR_MARCHID:       csr_data = '0;
			CSR_MIMPID, CSR_MHARTID:          csr_data = '0;
			CSR_MSTATUS:                      csr_data = mstatus_word;
			CSR_SSTATUS:                      csr_data = sstatus_word;
			CSR_MIE:                          csr_data = mie_word;
			CSR_SIE:                          csr_data = sie_word;
			CSR_MIP:                          csr_data = mip_word;
			CSR_SIP:                          csr_data = sip_word;
			CSR_MTVEC:                        csr_data = mtvec;
			CSR_STVEC:                        csr_data = stvec;
			CSR_MEPC:                         csr_data = mepc;
			CSR_SEPC:                         csr_data = sepc;
			CSR_MCAUSE:                       csr_data = mcause;
			CSR_SCAUSE:                       csr_data = scause;
			CSR_MTVAL:                        csr_data = mtval;
			CSR_STVAL:                        csr_data = stval;
			CSR_MSCRATCH:                     csr_data = mscratch;
			CSR_SSCRATCH:                     csr_data = sscratch;
			CSR_MEDELEG:                      csr_data = {16'b0, medeleg};
			CSR_MIDELEG:                      csr_data = {16'b0, mideleg};
			CSR_MTIMECMP:                     csr_data = mtimecmp;
			CSR_TIME, CSR_CYCLE:              csr_data = time_value[31:0];
			CSR_TIMEH, CSR_CYCLEH:            csr_data = time_value[63:32];
			default:                          csr_data = '0; // unmapped
		endcase
	end

	// return address on xret, otherwise the vector of the target mode
	always_comb
	begin
		if (m_ret)
			epc = mepc;
		else if (s_ret)
			epc = sepc;
		else if (next_mode == PRIV_S)
			epc = stvec;
		else
			epc = mtvec;
	end

endmodule

/* csr_file.sv */
`timescale 1ns/1ps

module csr_file
	import csr_pkg::*, trap_pkg::*;
(
	input  logic       clk,
	input  logic       nrst,
	input  logic       csr_we,
	input  csr_addr_t  csr_address_r,
	input  csr_addr_t  csr_address_wb,
	input  xlen_t      csr_wb,
	input  logic       exception_pending,
	input  xlen_t      cause,
	input  xlen_t      pc_exc,
	input  logic       m_ret,
	input  logic       s_ret,
	input  logic       m_interrupt,
	input  logic       s_interrupt,
	output xlen_t      csr_data,
	output xlen_t      epc,
	output priv_mode_t current_mode,
	output logic       m_eie,
	output logic       m_tie,
	output logic       s_eie,
	output logic       s_tie,
	output logic       tsr,
	output logic       m_timer
);

	priv_mode_t  next_mode, mpp;
	logic        spp;
	xlen_t       mstatus_word, sstatus_word, mie_word, sie_word;
	xlen_t       mtvec, stvec, mepc, sepc, mcause, scause;
	xlen_t       mtval, stval, mscratch, sscratch, mtimecmp;
	logic [15:0] medeleg, mideleg;
	time_t       time_value;

	trap_router u_router (.exception_pending, .cause, .m_ret, .s_ret, .current_mode,
		.mpp, .spp, .medeleg, .mideleg, .next_mode);

	csr_state u_state (.clk, .nrst, .csr_we, .csr_address_wb, .csr_wb, .exception_pending,
		.cause, .pc_exc, .m_ret, .s_ret, .next_mode, .current_mode, .mpp, .spp,
		.mstatus_word, .sstatus_word, .mie_word, .sie_word, .mtvec, .stvec, .mepc, .sepc,
		.mcause, .scause, .mtval, .stval, .mscratch, .sscratch, .medeleg, .mideleg,
		.m_eie, .m_tie, .s_eie, .s_tie, .tsr);

	machine_timer u_timer (.clk, .nrst, .csr_we, .csr_address_wb, .csr_wb,
		.exception_pending, .time_value, .mtimecmp, .m_timer);

	csr_read_port u_read (.csr_address_r, .next_mode, .m_ret, .s_ret, .mstatus_word,
		.sstatus_word, .mie_word, .sie_word, .mtvec, .stvec, .mepc, .sepc, .mcause,
		.scause, .mtval, .stval, .mscratch, .sscratch, .medeleg, .mideleg, .time_value,
		.mtimecmp, .m_timer, .m_interrupt, .s_interrupt, .csr_data, .epc);

endmodule

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock
(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

endmodule

/* csr_file_tb.sv */
`timescale 1ns/1ps

module csr_file_tb
	import csr_pkg::*, trap_pkg::*;
();

	localparam int PERIOD_NS       = 100;
	localparam int DRIVE_DLY       = 10;
	localparam int SAMPLE_DLY      = 40; // lands on the falling edge
	localparam int RESET_CYCLES    = 8;
	localparam int CYCLES_PER_LINE = 20;

	logic       clk, nrst, csr_we;
	csr_addr_t  csr_address_r, csr_address_wb;
	xlen_t      csr_wb, cause, pc_exc;
	logic       exception_pending, m_ret, s_ret, m_interrupt, s_interrupt;
	xlen_t      csr_data, epc;
	priv_mode_t current_mode;
	logic       m_eie, m_tie, s_eie, s_tie, tsr, m_timer;

	string       trace[$];
	logic        loaded = 1'b0;
	logic [15:0] lfsr;
	xlen_t       scratch_word;
	xlen_t       last_time;

	tb_clock u_clock (.clk);

	csr_file DUT (.clk, .nrst, .csr_we, .csr_address_r, .csr_address_wb, .csr_wb,
		.exception_pending, .cause, .pc_exc, .m_ret, .s_ret, .m_interrupt, .s_interrupt,
		.csr_data, .epc, .current_mode, .m_eie, .m_tie, .s_eie, .s_tie, .tsr, .m_timer);

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string name, input xlen_t exp, input xlen_t act);
		if (act !== exp)
			abort_run($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_mode(input string name, input priv_mode_t exp, input priv_mode_t act);
		if (act !== exp)
			abort_run($sformatf("FAILED %s: expected %s, actual %s", name, exp.name(),
				act.name()));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			abort_run($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
	endtask

	// galois form with taps 16, 14, 13 and 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	task automatic draw_word(output xlen_t w);
		w = '0;
		for (int i = 0; i < 32; i++)
		begin
			w = {lfsr[0], w[31:1]}; // one step per bit
			lfsr = lfsr_step(lfsr);
		end
	endtask

	function automatic logic output_bit(input xlen_t idx);
		case (idx)
			32'd0: return m_eie;
			32'd1: return m_tie;
			32'd2: return s_eie;
			32'd3: return s_tie;
			32'd4: return tsr;
			32'd5: return m_timer;
			default: return 1'bx;
		endcase
	endfunction

	task automatic next_edge();
		@(posedge clk);
		#(DRIVE_DLY);
	endtask

	task automatic run_line(input string line);
		string op, name;
		xlen_t a, b, c, w;
		int    n;
		n = $sscanf(line, "%s %s %h %h %h", op, name, a, b, c);
		if (n != 5)
			abort_run($sformatf("malformed trace line: %s", line));
		if (op == "wr" || op == "wrl")
		begin
			if (op == "wrl")
			begin
				draw_word(w);
				scratch_word = w;
			end
			else
				w = b;
			csr_we = 1'b1;
			csr_address_wb = a[11:0];
			csr_wb = w;
			next_edge();
			csr_we = 1'b0;
		end
		else if (op == "rd" || op == "rdl" || op == "tinc")
		begin
			csr_address_r = a[11:0];
			#(SAMPLE_DLY);
			if (op == "rd")
				check_word(name, c, csr_data);
			else if (op == "rdl")
				check_word(name, scratch_word, csr_data);
			else
			begin
				check_bit(name, 1'b1, csr_data > last_time); // time advances every cycle
				last_time = csr_data;
			end
			next_edge();
		end
		else if (op == "trap" || op == "mret" || op == "sret")
		begin
			exception_pending = (op == "trap");
			m_ret = (op == "mret");
			s_ret = (op == "sret");
			cause = a;
			pc_exc = b;
			#(SAMPLE_DLY);
			check_word(name, c, epc); // vector or return address in the trap cycle
			next_edge();
			{exception_pending, m_ret, s_ret} = 3'b000;
		end
		else if (op == "mode")
		begin
			#(SAMPLE_DLY);
			check_mode(name, priv_mode_t'(c[1:0]), current_mode);
			next_edge();
		end
		else if (op == "bit")
		begin
			#(SAMPLE_DLY);
			check_bit(name, c[0], output_bit(a));
			next_edge();
		end
		else if (op == "wait")
			repeat (a) next_edge();
		else
			abort_run($sformatf("unknown trace operation %s", op));
	endtask

	initial
	begin
		int    fd;
		string line;
		nrst = 1'b0;
		{csr_we, exception_pending, m_ret, s_ret, m_interrupt, s_interrupt} = '0;
		csr_address_r = '0;
		csr_address_wb = '0;
		{csr_wb, cause, pc_exc} = '0;
		lfsr = 16'd51609;
		scratch_word = '0;
		last_time = '0;
		fd = $fopen("csr_trace.txt", "r");
		if (fd == 0)
			abort_run("could not open csr_trace.txt");
		while (!$feof(fd))
		begin
			line = "";
			if ($fgets(line, fd) > 0 && line.len() > 1 && line.getc(0) != "#")
				trace.push_back(line);
		end
		$fclose(fd);
		loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#(DRIVE_DLY);
		nrst = 1'b1;
		foreach (trace[i])
			run_line(trace[i]);
		$display("ALL TESTS PASSED");
		$finish;
	end

	initial
	begin
		longint limit_ns;
		wait (loaded);
		limit_ns = (longint'(trace.size()) * CYCLES_PER_LINE + RESET_CYCLES) * PERIOD_NS;
		#(limit_ns);
		abort_run("watchdog expired before the trace was finished");
	end

endmodule

/* csr_trace.txt */
# columns: op name a b c (numbers in hex). wr/wrl: a=addr b=data. rd/rdl/tinc: a=addr c=expected
# trap: a=cause b=pc c=epc; mret/sret/mode: c=expected; bit: a=output index c=expected; wait: a=cycles
rd misa_reset 301 0 40143100
rd mvendorid_zero f11 0 0
rd marchid_zero f12 0 0
rd mimpid_zero f13 0 0
rd mhartid_zero f14 0 0
mode mode_reset 0 0 3
bit m_eie_reset 0 0 0
bit m_tie_reset 1 0 0
bit s_eie_reset 2 0 0
bit s_tie_reset 3 0 0
bit tsr_reset 4 0 0
wrl mscratch_lfsr 340 0 0
rdl mscratch_back 340 0 0
wrl sscratch_lfsr 140 0 0
rdl sscratch_back 140 0 0
wr mepc_wr 341 12345677 0
rd mepc_mask 341 0 12345674
wr mtvec_wr 305 80000103 0
rd mtvec_mask 305 0 80000100
wr stvec_wr 105 40000202 0
wr mcause_wr 342 ffffffc5 0
rd mcause_mask 342 0 80000005
wr sstatus_wr 100 2 0
rd mstatus_via_s 300 0 1802
wr sie_wr 104 220 0
rd mie_via_s 304 0 220
bit s_tie_on 3 0 1
bit m_eie_off 0 0 0
wr mie_wr 304 a20 0
bit m_eie_gated 0 0 0
wr mstatus_wr 300 180a 0
bit m_eie_on 0 0 1
trap trap_m 2 1002 80000100
rd mepc_trap 341 0 1000
rd mcause_trap 342 0 2
rd mtval_trap 343 0 0
rd mstatus_trap 300 0 1882
mode mode_after_trap 0 0 3
trap trap_misalign 0 2003 80000100
rd mepc_misalign 341 0 2000
rd mtval_misalign 343 0 2002
wr mstatus_mpp_s 300 88a 0
mret mret_to_s 0 0 2000
mode mode_after_mret 0 0 1
rd mstatus_mret 300 0 8a
wr medeleg_wr 302 4 0
trap trap_s 2 3006 40000200
rd sepc_trap 141 0 3004
rd scause_trap 142 0 2
rd stval_trap 143 0 0
rd sstatus_trap 100 0 120
mode mode_deleg 0 0 1
sret sret_to_s 0 0 3004
mode mode_sret 0 0 1
rd sstatus_sret 100 0 22
wr mideleg_wr 303 200 0
trap trap_int_s 80000009 4000 40000200
rd scause_int 142 0 80000009
sret sret_int 0 0 4000
sret sret_to_u 0 0 4000
mode mode_user 0 0 0
trap trap_from_u 8 5000 80000100
mode mode_from_u 0 0 3
mret mret_to_u 0 0 5000
mode mode_mret_u 0 0 0
tinc time_first c01 0 0
wait settle_a 3 0 0
tinc time_second c01 0 0
wr mtimecmp_low bbf 1 0
wait settle_b 2 0 0
bit m_timer_high 5 0 1
rd mip_timer 344 0 80
wr mtimecmp_max bbf ffffffff 0
rd mtimecmp_back bbf 0 ffffffff
wait settle_c 2 0 0
bit m_timer_low 5 0 0
rd mip_clear 344 0 0

/* sources.f */
csr_pkg.sv
trap_pkg.sv
trap_router.sv
csr_state.sv
machine_timer.sv
csr_read_port.sv
csr_file.sv
tb_clock.sv
csr_file_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the csr file testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module csr_file_tb -f sources.f -o sim_csr_file
./obj_dir/sim_csr_file | tee sim.log
if grep -q "ALL TESTS PASSED" sim.log
then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
